// File: mips_pkg.sv
package mips_pkg;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addi    = 6'h08;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_cop0    = 6'h10;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function codes
    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_srl     = 6'h02;
    localparam logic [5:0] fn_sra     = 6'h03;
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_break   = 6'h0d;
    localparam logic [5:0] fn_eret    = 6'h18; // under cop0 with co set
    localparam logic [5:0] fn_add     = 6'h20;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_sub     = 6'h22;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_nor     = 6'h27;
    localparam logic [5:0] fn_slt     = 6'h2a;
    localparam logic [5:0] fn_sltu    = 6'h2b;

    localparam logic [4:0] cop0_co    = 5'h10; // rs field of eret

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_view_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_view_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } j_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
        j_view_t j;
    } instr_u;

    typedef enum logic [3:0] {
        alu_add      = 4'd0, // zero bundle decodes as add
        alu_sub      = 4'd1,
        alu_and      = 4'd2,
        alu_or       = 4'd3,
        alu_xor      = 4'd4,
        alu_nor      = 4'd5,
        alu_slt      = 4'd6,
        alu_sltu     = 4'd7,
        alu_sll      = 4'd8,
        alu_srl      = 4'd9,
        alu_sra      = 4'd10,
        alu_lui      = 4'd11,
        alu_pass_pc8 = 4'd12
    } alu_op_e;

    typedef enum logic {
        src_rt  = 1'b0,
        src_imm = 1'b1
    } src_b_e;

    typedef enum logic [2:0] {
        br_none   = 3'd0,
        br_beq    = 3'd1,
        br_bne    = 3'd2,
        br_j_imme = 3'd3,
        br_jr     = 3'd4
    } br_kind_e;

    typedef struct packed {
        logic in_delay_slot;
        logic is_eret;
        logic is_syscall;
        logic is_break;
        logic is_ri;
        logic check_ov;
    } exc_flags_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs_data;
        logic [31:0] rt_data;
        logic [31:0] ext_imme;
        logic [25:0] j_imme;
        logic [4:0]  sa;
        logic [4:0]  w_reg_dst;
        logic        w_reg_ena;
        alu_op_e     alu_op;
        src_b_e      src_b;
        br_kind_e    br_kind;
        logic        is_ls;
        exc_flags_t  exc;
    } id2_bundle_t;

    typedef struct packed {
        logic [31:0] result;
        logic [4:0]  w_reg_dst;
        logic        w_reg_ena;
        logic        branch_taken;
        logic [31:0] branch_target;
        exc_flags_t  exc;
        logic        ov;
    } ex_out_t;

endpackage

// File: id2_decode.sv
`timescale 1ns/1ps

module id2_decode import mips_pkg::*; (
    input  instr_u      instr_i,
    input  logic [31:0] pc_i,
    input  logic        in_delay_slot_i,
    input  logic [31:0] rs_data_i,
    input  logic [31:0] rt_data_i,
    output id2_bundle_t bundle_o
);
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    alu_op_e     alu_op;
    src_b_e      src_b;
    br_kind_e    br_kind;
    logic [4:0]  w_reg_dst;
    logic        wr_en;
    logic        zero_ext;
    logic        is_ls;
    exc_flags_t  exc;

    assign opcode = instr_i.r.opcode;
    assign funct  = instr_i.r.funct;
    assign imm16  = instr_i.i.imm16;

    always_comb begin
        alu_op    = alu_add;
        src_b     = src_rt;
        br_kind   = br_none;
        w_reg_dst = instr_i.i.rt; // i-type writes rt
        wr_en     = 1'b0;
        zero_ext  = 1'b0;
        is_ls     = 1'b0;
        exc       = '0;
        exc.in_delay_slot = in_delay_slot_i;

        case (opcode)
            op_special: begin
                w_reg_dst = instr_i.r.rd;
                wr_en     = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_add: begin
                        alu_op       = alu_add;
                        exc.check_ov = 1'b1;
                    end
                    fn_subu: alu_op = alu_sub;
                    fn_sub: begin
                        alu_op       = alu_sub;
                        exc.check_ov = 1'b1;
                    end
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    fn_sra:  alu_op = alu_sra;
                    fn_jr: begin
                        br_kind = br_jr;
                        wr_en   = 1'b0;
                    end
                    fn_syscall: begin
                        exc.is_syscall = 1'b1;
                        wr_en          = 1'b0;
                    end
                    fn_break: begin
                        exc.is_break = 1'b1;
                        wr_en        = 1'b0;
                    end
                    default: begin
                        exc.is_ri = 1'b1;
                        wr_en     = 1'b0;
                    end
                endcase
            end
            op_addiu: begin
                src_b = src_imm;
                wr_en = 1'b1;
            end
            op_addi: begin
                src_b        = src_imm;
                wr_en        = 1'b1;
                exc.check_ov = 1'b1;
            end
            op_slti, op_sltiu: begin
                alu_op = (opcode == op_slti) ? alu_slt : alu_sltu;
                src_b  = src_imm;
                wr_en  = 1'b1;
            end
            op_andi, op_ori, op_xori: begin
                alu_op   = (opcode == op_andi) ? alu_and :
                           (opcode == op_ori)  ? alu_or  : alu_xor;
                src_b    = src_imm;
                zero_ext = 1'b1; // logical immediates
                wr_en    = 1'b1;
            end
            op_lui: begin
                alu_op = alu_lui;
                src_b  = src_imm;
                wr_en  = 1'b1;
            end
            op_lw, op_sw: begin
                src_b = src_imm; // effective address only
                is_ls = 1'b1;
                wr_en = (opcode == op_lw);
            end
            op_beq: br_kind = br_beq;
            op_bne: br_kind = br_bne;
            op_j:   br_kind = br_j_imme;
            op_jal: begin
                br_kind   = br_j_imme;
                alu_op    = alu_pass_pc8;
                w_reg_dst = 5'd31; // link register
                wr_en     = 1'b1;
            end
            op_cop0: begin
                if (funct == fn_eret && instr_i.r.rs == cop0_co) begin
                    exc.is_eret = 1'b1;
                end else begin
                    exc.is_ri = 1'b1;
                end
            end
            default: exc.is_ri = 1'b1;
        endcase
    end

    always_comb begin
        bundle_o.pc        = pc_i;
        bundle_o.rs_data   = rs_data_i;
        bundle_o.rt_data   = rt_data_i;
        bundle_o.ext_imme  = zero_ext ? {16'h0, imm16} : {{16{imm16[15]}}, imm16};
        bundle_o.j_imme    = instr_i.j.target26;
        bundle_o.sa        = instr_i.r.sa;
        bundle_o.w_reg_dst = w_reg_dst;
        bundle_o.w_reg_ena = wr_en && (w_reg_dst != 5'd0); // $zero never written
        bundle_o.alu_op    = alu_op;
        bundle_o.src_b     = src_b;
        bundle_o.br_kind   = br_kind;
        bundle_o.is_ls     = is_ls;
        bundle_o.exc       = exc;
    end

endmodule

// File: id2_ex.sv
`timescale 1ns/1ps

module id2_ex import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        flush_i,
    input  logic        stall_i,
    input  id2_bundle_t bundle_i,
    output id2_bundle_t ex_bundle_o
);
    logic bubble;

    // a stalled stage keeps its instruction even when a flush is pending
    assign bubble = rst_i || (flush_i && !stall_i);

    always_ff @(posedge clk) begin
        if (bubble) begin
            ex_bundle_o <= '0; // zero bundle is a nop
        end else if (!stall_i) begin
            ex_bundle_o <= bundle_i;
        end
    end

endmodule

// File: ex_stage.sv
`timescale 1ns/1ps

module ex_stage import mips_pkg::*; (
    input  id2_bundle_t bundle_i,
    output ex_out_t     ex_o
);
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] sum;
    logic [31:0] diff;
    logic [31:0] pc_plus4;
    logic [31:0] alu_res;
    logic        add_ov;
    logic        sub_ov;
    logic        ov;
    logic        taken;
    logic [31:0] target;

    assign op_a     = bundle_i.rs_data;
    assign op_b     = (bundle_i.src_b == src_imm) ? bundle_i.ext_imme : bundle_i.rt_data;
    assign sum      = op_a + op_b;
    assign diff     = op_a - op_b;
    assign pc_plus4 = bundle_i.pc + 32'd4;

    // signed overflow from the operand and result sign bits
    assign add_ov = (op_a[31] == op_b[31]) && (sum[31] != op_a[31]);
    assign sub_ov = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);
    assign ov     = bundle_i.exc.check_ov &&
                    ((bundle_i.alu_op == alu_sub) ? sub_ov : add_ov);

    always_comb begin
        case (bundle_i.alu_op)
            alu_add:      alu_res = sum; // also the ls address
            alu_sub:      alu_res = diff;
            alu_and:      alu_res = op_a & op_b;
            alu_or:       alu_res = op_a | op_b;
            alu_xor:      alu_res = op_a ^ op_b;
            alu_nor:      alu_res = ~(op_a | op_b);
            alu_slt:      alu_res = {31'h0, $signed(op_a) < $signed(op_b)};
            alu_sltu:     alu_res = {31'h0, op_a < op_b};
            alu_sll:      alu_res = bundle_i.rt_data << bundle_i.sa;
            alu_srl:      alu_res = bundle_i.rt_data >> bundle_i.sa;
            alu_sra:      alu_res = $unsigned($signed(bundle_i.rt_data) >>> bundle_i.sa);
            alu_lui:      alu_res = {bundle_i.ext_imme[15:0], 16'h0};
            alu_pass_pc8: alu_res = bundle_i.pc + 32'd8; // jal link value
            default:      alu_res = 32'h0;
        endcase
    end

    always_comb begin
        taken  = 1'b0;
        target = 32'h0;
        case (bundle_i.br_kind)
            br_beq: begin
                taken  = (bundle_i.rs_data == bundle_i.rt_data);
                target = pc_plus4 + {bundle_i.ext_imme[29:0], 2'b00};
            end
            br_bne: begin
                taken  = (bundle_i.rs_data != bundle_i.rt_data);
                target = pc_plus4 + {bundle_i.ext_imme[29:0], 2'b00};
            end
            br_j_imme: begin
                taken  = 1'b1;
                target = {pc_plus4[31:28], bundle_i.j_imme, 2'b00}; // region jump
            end
            br_jr: begin
                taken  = 1'b1;
                target = bundle_i.rs_data;
            end
            default: begin
                taken  = 1'b0;
                target = 32'h0;
            end
        endcase
    end

    always_comb begin
        ex_o.result        = alu_res;
        ex_o.w_reg_dst     = bundle_i.w_reg_dst;
        ex_o.w_reg_ena     = bundle_i.w_reg_ena && !ov; // no writeback on overflow
        ex_o.branch_taken  = taken;
        ex_o.branch_target = target;
        ex_o.exc           = bundle_i.exc;
        ex_o.ov            = ov;
    end

endmodule

// File: id2_ex_top.sv
`timescale 1ns/1ps

module id2_ex_top import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        stall_i,
    input  logic        flush_i,
    input  instr_u      instr_i,
    input  logic [31:0] pc_i,
    input  logic        in_delay_slot_i,
    input  logic [31:0] rs_data_i,
    input  logic [31:0] rt_data_i,
    output ex_out_t     ex_o
);
    id2_bundle_t id2_bundle;
    id2_bundle_t ex_bundle;

    id2_decode u_id2_decode (
        .instr_i         (instr_i),
        .pc_i            (pc_i),
        .in_delay_slot_i (in_delay_slot_i),
        .rs_data_i       (rs_data_i),
        .rt_data_i       (rt_data_i),
        .bundle_o        (id2_bundle)
    );

    id2_ex u_id2_ex (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .stall_i     (stall_i),
        .bundle_i    (id2_bundle),
        .ex_bundle_o (ex_bundle)
    );

    ex_stage u_ex_stage (
        .bundle_i (ex_bundle),
        .ex_o     (ex_o)
    );

endmodule

// File: tb_id2_ex_top.sv
`timescale 1ns/1ps

module tb_id2_ex_top import mips_pkg::*; ();

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        ds;
        logic [31:0] rs;
        logic [31:0] rt;
        logic        stall;
        logic        flush;
        logic        res_valid; // result is compared only when set
        ex_out_t     exp;
    } row_t;

    logic        clk;
    logic        rst_i;
    logic        stall_i;
    logic        flush_i;
    instr_u      instr_i;
    logic [31:0] pc_i;
    logic        in_delay_slot_i;
    logic [31:0] rs_data_i;
    logic [31:0] rt_data_i;
    ex_out_t     ex_o;

    row_t rows[$];
    logic table_ready = 1'b0;

    id2_ex_top u_id2_ex_top (
        .clk             (clk),
        .rst_i           (rst_i),
        .stall_i         (stall_i),
        .flush_i         (flush_i),
        .instr_i         (instr_i),
        .pc_i            (pc_i),
        .in_delay_slot_i (in_delay_slot_i),
        .rs_data_i       (rs_data_i),
        .rt_data_i       (rt_data_i),
        .ex_o            (ex_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] r_type(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                           logic [4:0] rd, logic [4:0] sa);
        r_type = {op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_type(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                           logic [15:0] imm);
        i_type = {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(logic [5:0] op, logic [25:0] target);
        j_type = {op, target};
    endfunction

    // exc bits in order delay slot, eret, syscall, break, ri, check_ov
    function automatic ex_out_t expect_out(logic [31:0] result, logic [4:0] dst, logic ena,
                                           logic taken, logic [31:0] target,
                                           logic [5:0] exc, logic ov);
        ex_out_t o;
        o.result        = result;
        o.w_reg_dst     = dst;
        o.w_reg_ena     = ena;
        o.branch_taken  = taken;
        o.branch_target = target;
        o.exc           = exc;
        o.ov            = ov;
        return o;
    endfunction

    // isa reference for the non-trapping alu instructions
    function automatic logic [31:0] ref_result(logic [31:0] ins, logic [31:0] a,
                                               logic [31:0] b);
        logic [31:0] sx;
        logic [31:0] zx;
        logic [4:0]  sh;
        sx = {{16{ins[15]}}, ins[15:0]};
        zx = {16'h0, ins[15:0]};
        sh = ins[10:6];
        ref_result = 32'h0;
        case (ins[31:26])
            op_special: begin
                case (ins[5:0])
                    fn_addu: ref_result = a + b;
                    fn_subu: ref_result = a - b;
                    fn_and:  ref_result = a & b;
                    fn_or:   ref_result = a | b;
                    fn_xor:  ref_result = a ^ b;
                    fn_nor:  ref_result = ~(a | b);
                    fn_slt:  ref_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fn_sltu: ref_result = (a < b) ? 32'd1 : 32'd0;
                    fn_sll:  ref_result = b << sh;
                    fn_srl:  ref_result = b >> sh;
                    fn_sra:  ref_result = $signed(b) >>> sh;
                    default: ref_result = 32'h0;
                endcase
            end
            op_addiu: ref_result = a + sx;
            op_andi:  ref_result = a & zx;
            op_ori:   ref_result = a | zx;
            op_xori:  ref_result = a ^ zx;
            op_slti:  ref_result = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            op_sltiu: ref_result = (a < sx) ? 32'd1 : 32'd0;
            op_lui:   ref_result = {ins[15:0], 16'h0};
            default:  ref_result = 32'h0;
        endcase
    endfunction

    task automatic add_row(logic [31:0] ins, logic [31:0] pc, logic ds, logic [31:0] rs,
                           logic [31:0] rt, logic stall, logic flush, logic res_valid,
                           ex_out_t exp);
        row_t r;
        r.instr     = ins;
        r.pc        = pc;
        r.ds        = ds;
        r.rs        = rs;
        r.rt        = rt;
        r.stall     = stall;
        r.flush     = flush;
        r.res_valid = res_valid;
        r.exp       = exp;
        rows.push_back(r);
    endtask

    task automatic add_random_alu(logic [31:0] ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  dst;
        a   = $urandom();
        b   = $urandom();
        dst = (ins[31:26] == op_special) ? ins[15:11] : ins[20:16];
        add_row(ins, 32'h0000_0400, 1'b0, a, b, 1'b0, 1'b0, 1'b1,
                expect_out(ref_result(ins, a, b), dst, 1'b1, 1'b0, 32'h0, 6'h0, 1'b0));
    endtask

    task automatic build_table();
        repeat (2) begin
            add_random_alu(r_type(fn_addu, 5'd1, 5'd2, 5'd3, 5'd0));
            add_random_alu(r_type(fn_subu, 5'd1, 5'd2, 5'd3, 5'd0));
            add_random_alu(r_type(fn_and,  5'd1, 5'd2, 5'd3, 5'd0));
            add_random_alu(r_type(fn_or,   5'd1, 5'd2, 5'd3, 5'd0));
            add_random_alu(r_type(fn_xor,  5'd1, 5'd2, 5'd3, 5'd0));
            add_random_alu(r_type(fn_nor,  5'd1, 5'd2, 5'd3, 5'd0));
            add_random_alu(r_type(fn_slt,  5'd1, 5'd2, 5'd3, 5'd0));
            add_random_alu(r_type(fn_sltu, 5'd1, 5'd2, 5'd3, 5'd0));
            add_random_alu(r_type(fn_sll,  5'd0, 5'd2, 5'd3, 5'($urandom())));
            add_random_alu(r_type(fn_srl,  5'd0, 5'd2, 5'd3, 5'($urandom())));
            add_random_alu(r_type(fn_sra,  5'd0, 5'd2, 5'd3, 5'($urandom())));
            add_random_alu(i_type(op_addiu, 5'd1, 5'd2, 16'($urandom())));
            add_random_alu(i_type(op_andi,  5'd1, 5'd2, 16'($urandom())));
            add_random_alu(i_type(op_ori,   5'd1, 5'd2, 16'($urandom())));
            add_random_alu(i_type(op_xori,  5'd1, 5'd2, 16'($urandom())));
            add_random_alu(i_type(op_slti,  5'd1, 5'd2, 16'($urandom())));
            add_random_alu(i_type(op_sltiu, 5'd1, 5'd2, 16'($urandom())));
            add_random_alu(i_type(op_lui,   5'd0, 5'd2, 16'($urandom())));
        end
        // write to $zero is dropped
        add_row(r_type(fn_addu, 5'd1, 5'd2, 5'd0, 5'd0), 32'h100, 1'b0, 32'h5, 32'h7,
                1'b0, 1'b0, 1'b1, expect_out(32'hc, 5'd0, 1'b0, 1'b0, 32'h0, 6'h00, 1'b0));
        add_row(r_type(fn_addu, 5'd1, 5'd2, 5'd3, 5'd0), 32'h104, 1'b0, 32'h7fff_ffff, 32'h1,
                1'b0, 1'b0, 1'b1,
                expect_out(32'h8000_0000, 5'd3, 1'b1, 1'b0, 32'h0, 6'h00, 1'b0));
        add_row(r_type(fn_add, 5'd1, 5'd2, 5'd3, 5'd0), 32'h108, 1'b0, 32'h7fff_ffff, 32'h1,
                1'b0, 1'b0, 1'b0, expect_out(32'h0, 5'd3, 1'b0, 1'b0, 32'h0, 6'h01, 1'b1));
        add_row(r_type(fn_sub, 5'd1, 5'd2, 5'd3, 5'd0), 32'h10c, 1'b0, 32'h8000_0000, 32'h1,
                1'b0, 1'b0, 1'b0, expect_out(32'h0, 5'd3, 1'b0, 1'b0, 32'h0, 6'h01, 1'b1));
        add_row(i_type(op_addi, 5'd1, 5'd5, 16'h8000), 32'h110, 1'b0, 32'h8000_0000, 32'h0,
                1'b0, 1'b0, 1'b0, expect_out(32'h0, 5'd5, 1'b0, 1'b0, 32'h0, 6'h01, 1'b1));
        add_row(i_type(op_addiu, 5'd1, 5'd5, 16'h8000), 32'h114, 1'b0, 32'h8000_0000, 32'h0,
                1'b0, 1'b0, 1'b1,
                expect_out(32'h7fff_8000, 5'd5, 1'b1, 1'b0, 32'h0, 6'h00, 1'b0));
        add_row(i_type(op_addi, 5'd1, 5'd5, 16'hfffe), 32'h118, 1'b0, 32'h10, 32'h0,
                1'b0, 1'b0, 1'b1, expect_out(32'he, 5'd5, 1'b1, 1'b0, 32'h0, 6'h01, 1'b0));
        add_row(i_type(op_andi, 5'd1, 5'd4, 16'h8f0f), 32'h11c, 1'b0, 32'hffff_ffff, 32'h0,
                1'b0, 1'b0, 1'b1, expect_out(32'h8f0f, 5'd4, 1'b1, 1'b0, 32'h0, 6'h00, 1'b0));
        // branches and jumps
        add_row(i_type(op_beq, 5'd1, 5'd2, 16'h0004), 32'h1000, 1'b0, 32'h55, 32'h55,
                1'b0, 1'b0, 1'b0, expect_out(32'h0, 5'd0, 1'b0, 1'b1, 32'h1014, 6'h00, 1'b0));
        add_row(i_type(op_beq, 5'd1, 5'd2, 16'h0004), 32'h1000, 1'b0, 32'h1, 32'h2,
                1'b0, 1'b0, 1'b0, expect_out(32'h0, 5'd0, 1'b0, 1'b0, 32'h0, 6'h00, 1'b0));
        add_row(i_type(op_bne, 5'd1, 5'd2, 16'hfffc), 32'h2000, 1'b0, 32'h1, 32'h2,
                1'b0, 1'b0, 1'b0, expect_out(32'h0, 5'd0, 1'b0, 1'b1, 32'h1ff4, 6'h00, 1'b0));
        add_row(i_type(op_bne, 5'd1, 5'd2, 16'hfffc), 32'h2000, 1'b0, 32'h9, 32'h9,
                1'b0, 1'b0, 1'b0, expect_out(32'h0, 5'd0, 1'b0, 1'b0, 32'h0, 6'h00, 1'b0));
        add_row(j_type(op_j, 26'h0123456), 32'h4000_0100, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0,
                1'b0, expect_out(32'h0, 5'd0, 1'b0, 1'b1, 32'h4048_d158, 6'h00, 1'b0));
        add_row(j_type(op_jal, 26'h0000400), 32'h3000, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0,
                1'b1, expect_out(32'h3008, 5'd31, 1'b1, 1'b1, 32'h1000, 6'h00, 1'b0));
        add_row(r_type(fn_jr, 5'd4, 5'd0, 5'd0, 5'd0), 32'h3100, 1'b0, 32'h8000_0040, 32'h0,
                1'b0, 1'b0, 1'b0,
                expect_out(32'h0, 5'd0, 1'b0, 1'b1, 32'h8000_0040, 6'h00, 1'b0));
        // flagged instructions with some in a delay slot
        add_row(r_type(fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0), 32'h200, 1'b1, 32'h0, 32'h0,
                1'b0, 1'b0, 1'b0, expect_out(32'h0, 5'd0, 1'b0, 1'b0, 32'h0, 6'h28, 1'b0));
        add_row(r_type(fn_break, 5'd0, 5'd0, 5'd0, 5'd0), 32'h204, 1'b0, 32'h0, 32'h0,
                1'b0, 1'b0, 1'b0, expect_out(32'h0, 5'd0, 1'b0, 1'b0, 32'h0, 6'h04, 1'b0));
        add_row(32'h4200_0018, 32'h208, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0,
                expect_out(32'h0, 5'd0, 1'b0, 1'b0, 32'h0, 6'h10, 1'b0)); // eret
        add_row(32'hfc00_0000, 32'h20c, 1'b1, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0,
                expect_out(32'h0, 5'd0, 1'b0, 1'b0, 32'h0, 6'h22, 1'b0)); // opcode 3f
        // stall holds and flush alone gives a bubble
        add_row(i_type(op_ori, 5'd1, 5'd7, 16'h00f0), 32'h300, 1'b0, 32'h0f00, 32'h0,
                1'b0, 1'b0, 1'b1, expect_out(32'h0ff0, 5'd7, 1'b1, 1'b0, 32'h0, 6'h00, 1'b0));
        add_row(i_type(op_xori, 5'd1, 5'd8, 16'h1234), 32'h304, 1'b0, 32'h1, 32'h0,
                1'b1, 1'b1, rows[$].res_valid, rows[$].exp);
        add_row(i_type(op_xori, 5'd1, 5'd8, 16'h1234), 32'h304, 1'b0, 32'h1, 32'h0,
                1'b1, 1'b0, rows[$].res_valid, rows[$].exp);
        add_row(i_type(op_xori, 5'd1, 5'd8, 16'h1234), 32'h304, 1'b0, 32'h1, 32'h0,
                1'b0, 1'b1, 1'b1, expect_out(32'h0, 5'd0, 1'b0, 1'b0, 32'h0, 6'h00, 1'b0));
        add_row(i_type(op_lw, 5'd1, 5'd6, 16'hfff8), 32'h308, 1'b0, 32'h1000, 32'h0,
                1'b0, 1'b0, 1'b1, expect_out(32'h0ff8, 5'd6, 1'b1, 1'b0, 32'h0, 6'h00, 1'b0));
        add_row(i_type(op_sw, 5'd1, 5'd6, 16'h0010), 32'h30c, 1'b0, 32'h1000, 32'h0,
                1'b0, 1'b0, 1'b1, expect_out(32'h1010, 5'd6, 1'b0, 1'b0, 32'h0, 6'h00, 1'b0));
    endtask

    task automatic drive_row(row_t r);
        instr_i         <= r.instr;
        pc_i            <= r.pc;
        in_delay_slot_i <= r.ds;
        rs_data_i       <= r.rs;
        rt_data_i       <= r.rt;
        stall_i         <= r.stall;
        flush_i         <= r.flush;
    endtask

    task automatic report_mismatch(int idx, string name, logic [127:0] got,
                                   logic [127:0] exp);
        $display("mismatch %s at row %0d: got %0h expected %0h", name, idx, got, exp);
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_row(int idx, row_t r);
        if (r.res_valid) begin
            assert (ex_o.result == r.exp.result)
                else report_mismatch(idx, "result", ex_o.result, r.exp.result);
        end
        assert (ex_o.w_reg_ena == r.exp.w_reg_ena)
            else report_mismatch(idx, "w_reg_ena", ex_o.w_reg_ena, r.exp.w_reg_ena);
        if (r.exp.w_reg_ena) begin // dst only matters for a write
            assert (ex_o.w_reg_dst == r.exp.w_reg_dst)
                else report_mismatch(idx, "w_reg_dst", ex_o.w_reg_dst, r.exp.w_reg_dst);
        end
        assert (ex_o.branch_taken == r.exp.branch_taken)
            else report_mismatch(idx, "branch_taken", ex_o.branch_taken, r.exp.branch_taken);
        if (r.exp.branch_taken) begin
            assert (ex_o.branch_target == r.exp.branch_target)
                else report_mismatch(idx, "branch_target", ex_o.branch_target,
                                     r.exp.branch_target);
        end
        assert (ex_o.exc == r.exp.exc)
            else report_mismatch(idx, "exc", ex_o.exc, r.exp.exc);
        assert (ex_o.ov == r.exp.ov)
            else report_mismatch(idx, "ov", ex_o.ov, r.exp.ov);
        if (r.flush && !r.stall) begin
            assert (ex_o == '0)
                else report_mismatch(idx, "ex_o", ex_o, 128'h0);
        end
    endtask

    initial begin
        wait (table_ready);
        #((rows.size() + 10) * 10); // one cycle per row plus reset and margin
        $display("timeout: the run did not finish in the expected time");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_i           = 1'b1;
        stall_i         = 1'b0;
        flush_i         = 1'b0;
        instr_i         = '0;
        pc_i            = '0;
        in_delay_slot_i = 1'b0;
        rs_data_i       = '0;
        rt_data_i       = '0;
        void'($urandom(32'h6ad8));
        build_table();
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        drive_row(rows[0]);
        @(negedge clk);
        assert (ex_o == '0)
            else report_mismatch(-1, "ex_o", ex_o, 128'h0); // still the reset value

        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            if (i + 1 < rows.size()) begin
                drive_row(rows[i + 1]);
            end
            @(negedge clk);
            check_row(i, rows[i]);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: sources.f
mips_pkg.sv
id2_decode.sv
id2_ex.sv
ex_stage.sv
id2_ex_top.sv
tb_id2_ex_top.sv
